// ==== Makefile ====
# Verilator build and run of the flush subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_flush_subsys
FILELIST  ?= flush_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/flush_checker.sv ====
// Checker module of the testbench that models strobes, halt window and writeback order
module flush_checker
    import flush_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [7:0]            events_i,       // Debug, eret, ex, csr, sfence, fence.i, fence, bp
    input  logic                  halt_csr_i,
    input  logic [6:0]            strobes_i,      // Tlb, icache, ex, id, unissued, if, pc_commit
    input  logic                  halt_i,
    input  logic                  store_valid_i,
    input  logic [LINE_IDX_W-1:0] store_idx_i,
    input  logic [DATA_W-1:0]     store_data_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic                  pready_i,
    input  logic [ADDR_W-1:0]     paddr_i,
    input  logic [DATA_W-1:0]     pwdata_i,
    input  logic                  flush_dcache_i, // Probed controller request
    input  logic                  flush_ack_i,    // Probed unit ack
    input  logic [2:0]            test_id_i,
    input  logic                  test_end_i,     // Close current test
    input  logic                  done_i,         // Print summary
    output int                    failed_tests_o
);

    logic [DATA_W-1:0]   mdata [NR_LINES]; // Last value stored per line
    logic [NR_LINES-1:0] mdirty;
    logic                fence_act;        // Model of the fence window
    int unsigned         wb_idx_q [$];     // Expected writebacks in ascending order
    logic [DATA_W-1:0]   wb_data_q [$];
    int                  test_errs = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  failed = 0;

    assign failed_tests_o = failed;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_state";
            3'd1:    return "strobe_vectors";
            3'd2:    return "fence_writeback";
            3'd3:    return "back_pressure";
            3'd4:    return "halt_window";
            default: return "fence_i_sfence_vma";
        endcase
    endfunction

    // Strobe rules with bit 0 as set_pc_commit
    function automatic logic [6:0] model_strobes(input logic [7:0] ev);
        logic [6:0] s;
        s = '0;
        if (ev[0]) s[2:1] = 2'b11;      // Mispredict
        if (|ev[4:1]) s[4:0] = 5'h1f;   // Fence, fence.i, sfence, csr
        if (ev[2]) s[5] = 1'b1;
        if (ev[3]) s[6] = 1'b1;
        if (|ev[7:5]) begin
            s[4:1] = 4'hf;
            s[0]   = 1'b0;              // Trap target wins
        end
        return s;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     test_name(test_id_i), what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report(input string msg);
        $display("ERROR in %s: %s", test_name(test_id_i), msg);
        test_errs++;
    endtask

    // ----------------------------------------
    // Sampled at the falling edge
    // ----------------------------------------
    always @(negedge clk_i) begin : watch
        if (!rst_ni) begin
            fence_act = 1'b0;
            mdirty    = '0;
            wb_idx_q.delete();
            wb_data_q.delete();
            for (int i = 0; i < NR_LINES; i++) mdata[i] = '0;
        end else begin
            check_val("strobes", 32'(model_strobes(events_i)), 32'(strobes_i));
            check_val("halt", 32'(halt_csr_i | fence_act), 32'(halt_i));
            check_val("dcache flush request", 32'(fence_act), 32'(flush_dcache_i));
            if (psel_i && !fence_act) report("APB transfer with no fence pending");
            if (psel_i) check_val("pwrite", 32'd1, 32'(pwrite_i)); // Writebacks only
            if (flush_ack_i && !fence_act) report("flush ack with no fence pending");
            if (psel_i && penable_i && pready_i) begin   // Transfer ends this cycle
                if (wb_idx_q.size() == 0) begin
                    report("APB write although no dirty line was left");
                end else begin
                    check_val("writeback address", WB_BASE + 32'(4 * wb_idx_q[0]), paddr_i);
                    check_val("writeback data", wb_data_q[0], pwdata_i);
                    void'(wb_idx_q.pop_front());
                    void'(wb_data_q.pop_front());
                end
            end
            if (flush_ack_i && wb_idx_q.size() != 0)
                report($sformatf("flush acked with %0d writebacks missing", wb_idx_q.size()));
            if (events_i[1] || events_i[2]) begin         // Fence snapshots the dirty lines
                for (int i = 0; i < NR_LINES; i++) begin
                    if (mdirty[i]) begin
                        wb_idx_q.push_back(i);
                        wb_data_q.push_back(mdata[i]);
                    end
                end
                mdirty    = '0;
                fence_act = 1'b1;
            end else if (fence_act && flush_ack_i) begin
                fence_act = 1'b0;
            end
            if (store_valid_i) begin
                mdata[store_idx_i]  = store_data_i;
                mdirty[store_idx_i] = 1'b1;
            end
        end
        if (test_end_i) begin
            $display("%s: %s, %0d errors", test_name(test_id_i),
                     (test_errs == 0) ? "PASS" : "FAIL", test_errs);
            tests_run++;
            if (test_errs != 0) failed++;
            errors    += test_errs;
            test_errs  = 0;
        end
        if (done_i)
            $display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_run - failed, failed, checks, errors);
    end

endmodule

// ==== dv/tb_flush_subsys.sv ====
// Testbench top that drives events, stores and fences into the flush subsystem and answers APB
module tb_flush_subsys
    import flush_pkg::*;
();

    localparam logic [31:0] SEED      = 32'h6ec4_bebc;
    localparam int          N_VECTORS = 16; // Random strobe vectors
    localparam int          N_ROUNDS  = 3;  // Fence rounds per writeback test
    // One step is a vector or a fence round and is bounded by a full walk
    localparam int          N_STEPS     = 1 + N_VECTORS + 1 + 2 * N_ROUNDS + 2 + 2;
    localparam int          CYCLE_LIMIT = N_STEPS * (NR_LINES * 5 + 20);

    logic clk_i = 1'b0;
    logic rst_ni, halt_csr_i, store_valid_i;
    logic mispredict_i, fence_i, fence_i_i, sfence_vma_i, flush_csr_i;
    logic ex_valid_i, eret_i, set_debug_pc_i;
    logic set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o;
    logic flush_icache_o, flush_tlb_o, halt_o;
    logic [LINE_IDX_W-1:0] store_idx_i;
    logic [DATA_W-1:0]     store_data_i, pwdata_o;
    logic [ADDR_W-1:0]     paddr_o;
    logic psel_o, penable_o, pwrite_o, pslverr_i;
    logic pready_i = 1'b0;
    logic stall_en = 1'b0;                  // Random APB wait states on
    logic [31:0] stim_state, resp_state = SEED;
    int   wait_cnt = 0;
    int   cycles = 0;
    logic [7:0] events;
    logic [6:0] strobes;
    logic flush_dcache, flush_ack;          // Internal handshake probes
    logic [2:0] test_id;
    logic test_end, run_done;
    int   failed_tests;

    assign events  = {set_debug_pc_i, eret_i, ex_valid_i, flush_csr_i,
                      sfence_vma_i, fence_i_i, fence_i, mispredict_i};
    assign strobes = {flush_tlb_o, flush_icache_o, flush_ex_o, flush_id_o,
                      flush_unissued_o, flush_if_o, set_pc_commit_o};
    assign flush_dcache = i_flush_subsys.flush_dcache;
    assign flush_ack    = i_flush_subsys.flush_ack;

    flush_subsys i_flush_subsys (.*);

    flush_checker i_flush_checker (
        .*,
        .events_i       ( events       ),
        .strobes_i      ( strobes      ),
        .halt_i         ( halt_o       ),
        .psel_i         ( psel_o       ),
        .penable_i      ( penable_o    ),
        .pwrite_i       ( pwrite_o     ),
        .paddr_i        ( paddr_o      ),
        .pwdata_i       ( pwdata_o     ),
        .flush_dcache_i ( flush_dcache ),
        .flush_ack_i    ( flush_ack    ),
        .test_id_i      ( test_id      ),
        .test_end_i     ( test_end     ),
        .done_i         ( run_done     ),
        .failed_tests_o ( failed_tests )
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #1;                                 // Drive just after the edge
    endtask

    task automatic drive_events(input logic [7:0] ev);
        mispredict_i   = ev[0];
        fence_i        = ev[1];
        fence_i_i      = ev[2];
        sfence_vma_i   = ev[3];
        flush_csr_i    = ev[4];
        ex_valid_i     = ev[5];
        eret_i         = ev[6];
        set_debug_pc_i = ev[7];
    endtask

    task automatic pulse(input logic [7:0] ev);
        drive_events(ev);
        step();
        drive_events('0);
    endtask

    task automatic wait_release();
        while (halt_o) step();              // Core parked until the walk ends
    endtask

    task automatic store_burst(input int n);
        for (int k = 0; k < n; k++) begin
            store_valid_i = 1'b1;
            store_idx_i   = LINE_IDX_W'(rand32() % NR_LINES);
            store_data_i  = rand32();
            step();
        end
        store_valid_i = 1'b0;
    endtask

    task automatic fence_round(input logic [7:0] ev, input int n_stores);
        store_burst(n_stores);
        pulse(ev);
        wait_release();
    endtask

    task automatic end_test();
        test_end = 1'b1;
        step();
        test_end = 1'b0;
        test_id  = test_id + 1'b1;
    endtask

    // ----------------------------------------
    // APB memory with 0 to 3 wait states
    // ----------------------------------------
    always @(posedge clk_i) begin : apb_responder
        #1;
        if (psel_o && !penable_o) begin       // Setup phase picks the stall
            resp_state = xorshift32(resp_state);
            wait_cnt   = stall_en ? int'(resp_state % 4) : 0;
            pready_i   = 1'b0;
        end else if (psel_o && penable_o) begin
            pready_i = (wait_cnt == 0);
            if (wait_cnt != 0) wait_cnt--;
        end else begin
            pready_i = 1'b0;
        end
    end

    always @(posedge clk_i) begin : timeout
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a flush never completed", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        logic [7:0]  ev;
        rst_ni        = 1'b0;
        drive_events('0);
        halt_csr_i    = 1'b0;
        store_valid_i = 1'b0;
        store_idx_i   = '0;
        store_data_i  = '0;
        pslverr_i     = 1'b0;
        stim_state    = SEED;
        test_id       = '0;
        test_end      = 1'b0;
        run_done      = 1'b0;
        repeat (2) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        step();
        fence_round(8'h02, 0);              // Clean cache leaves nothing to write
        end_test();

        for (int v = 0; v < N_VECTORS; v++) begin
            r = rand32();
            if (r[16]) ev = 8'h01 << r[19:17]; // One-hot
            else ev = r[7:0] & r[15:8];        // Sparse mix
            halt_csr_i = r[20] & ~(ev[1] | ev[2]); // No fence under a CSR halt
            pulse(ev);
            halt_csr_i = 1'b0;
            wait_release();
        end
        pulse(8'h2a);                       // Exception over fence and sfence.vma
        wait_release();
        end_test();

        for (int n = 0; n < N_ROUNDS; n++) fence_round(8'h02, 1 + int'(rand32() % 12));
        end_test();

        stall_en = 1'b1;
        for (int n = 0; n < N_ROUNDS; n++) fence_round(8'h02, 4 + int'(rand32() % 20));
        end_test();

        fence_round(8'h02, 8);
        fence_round(8'h02, 0);              // Back to back with all lines clean now
        end_test();

        fence_round(8'h04, 5);              // Fence.i also drains the dcache
        pulse(8'h08);                       // Sfence.vma leaves it alone
        repeat (3) step();
        end_test();

        run_done = 1'b1;
        step();
        if (failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flush_subsys.f ====
rtl/flush_pkg.sv
rtl/controller.sv
rtl/dcache_flush_unit.sv
rtl/flush_subsys.sv
dv/flush_checker.sv
dv/tb_flush_subsys.sv

// ==== rtl/controller.sv ====
// Flush controller, turns pipeline events into stage flush strobes and runs the dcache fence handshake
module controller
    import flush_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    // Pipeline events, single-cycle pulses
    input  logic mispredict_i,       // Resolved branch was mispredicted
    input  logic fence_i,            // Fence committed
    input  logic fence_i_i,          // Fence.i committed
    input  logic sfence_vma_i,       // Sfence.vma committed
    input  logic flush_csr_i,        // CSR write with side effect
    input  logic ex_valid_i,         // Exception taken
    input  logic eret_i,             // Return from exception
    input  logic set_debug_pc_i,     // Debug mode entry
    input  logic halt_csr_i,         // Level halt from CSR file (WFI)
    // Flush strobes, same cycle as the event
    output logic set_pc_commit_o,    // PC gen takes the commit PC
    output logic flush_if_o,         // Flush fetch
    output logic flush_unissued_o,   // Drop un-issued scoreboard entries
    output logic flush_id_o,         // Flush decode
    output logic flush_ex_o,         // Flush execute
    output logic flush_icache_o,     // Invalidate the instruction cache
    output logic flush_tlb_o,        // Invalidate the TLBs
    // Data-cache flush handshake
    output logic flush_dcache_o,     // Registered request to the flush unit
    input  logic flush_dcache_ack_i, // One-cycle ack from the flush unit
    output logic halt_o              // Stall commit
);

    logic fence_start;                    // Fence or fence.i this cycle
    logic fence_active_d, fence_active_q; // Dcache flush in flight
    logic flush_dcache_d;

    assign fence_start = fence_i | fence_i_i;

    // ----------------------------------------
    // Strobe decode
    // ----------------------------------------
    always_comb begin : strobe_decode
        set_pc_commit_o  = 1'b0;
        flush_if_o       = 1'b0;
        flush_unissued_o = 1'b0;
        flush_id_o       = 1'b0;
        flush_ex_o       = 1'b0;
        flush_icache_o   = 1'b0;
        flush_tlb_o      = 1'b0;

        // Wrong path fetched, only the front is dirty
        if (mispredict_i) begin
            flush_unissued_o = 1'b1;
            flush_if_o       = 1'b1;
        end

        // Side-effect instructions restart from the commit PC
        if (fence_i || fence_i_i || sfence_vma_i || flush_csr_i) begin
            set_pc_commit_o  = 1'b1;
            flush_if_o       = 1'b1;
            flush_unissued_o = 1'b1;
            flush_id_o       = 1'b1;
            flush_ex_o       = 1'b1;
        end

        if (fence_i_i) begin
            flush_icache_o = 1'b1; // Fetched code may be stale
        end

        if (sfence_vma_i) begin
            flush_tlb_o = 1'b1; // Translations may be stale
        end

        // Trap, return or debug entry wins over everything above.
        // PC gen must take the trap vector, not the commit PC.
        if (ex_valid_i || eret_i || set_debug_pc_i) begin
            set_pc_commit_o  = 1'b0;
            flush_if_o       = 1'b1;
            flush_unissued_o = 1'b1;
            flush_id_o       = 1'b1;
            flush_ex_o       = 1'b1;
        end
    end

    // ----------------------------------------
    // Dcache fence handshake
    // ----------------------------------------
    always_comb begin : fence_ctrl
        fence_active_d = fence_active_q;
        flush_dcache_d = 1'b0;

        if (fence_start) begin
            fence_active_d = 1'b1; // New fence arms the handshake
            flush_dcache_d = 1'b1;
        end else if (fence_active_q && flush_dcache_ack_i) begin
            fence_active_d = 1'b0; // Unit finished the walk
        end else if (fence_active_q) begin
            flush_dcache_d = 1'b1; // Hold request until ack
        end
    end

    // Core stays parked while the dcache drains
    assign halt_o = halt_csr_i | fence_active_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_o <= flush_dcache_d; // Registered towards the cache
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    // Unit only reaches its ack state when a fence asked for it
    ack_needs_fence : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_ack_i |-> fence_active_q
    ) else $error("Dcache ack without active fence, unit passed state %0d unasked", ACK);

    // Request must not drop before the unit has answered
    req_held_until_ack : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (fence_active_q && !flush_dcache_ack_i) |=> flush_dcache_o
    ) else $error("Dcache flush request dropped before ack");

endmodule

// ==== rtl/dcache_flush_unit.sv ====
// Dirty-line store of the data cache, walks all lines on a flush and writes dirty ones back over APB
module dcache_flush_unit
    import flush_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Flush handshake with the controller
    input  logic                  flush_req_i,   // Held high until ack
    output logic                  flush_ack_o,   // One-cycle pulse at walk end
    // Store port from the core
    input  logic                  store_valid_i,
    input  logic [LINE_IDX_W-1:0] store_idx_i,
    input  logic [DATA_W-1:0]     store_data_i,
    // APB master, write only
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_W-1:0]     paddr_o,
    output logic [DATA_W-1:0]     pwdata_o,
    input  logic                  pready_i,
    input  logic                  pslverr_i      // Writeback does not retry on error
);

    walk_state_e           state_d, state_q;
    logic [LINE_IDX_W-1:0] idx_d, idx_q;       // Line under inspection
    logic                  last_line;
    logic                  clear_dirty;        // Current line written back

    logic [NR_LINES-1:0]   dirty_q;
    logic [DATA_W-1:0]     line_data_q [NR_LINES];

    assign last_line = (idx_q == LINE_IDX_W'(NR_LINES - 1));

    // ----------------------------------------
    // Walk FSM
    // ----------------------------------------
    always_comb begin : walk_fsm
        state_d     = state_q;
        idx_d       = idx_q;
        clear_dirty = 1'b0;
        flush_ack_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (flush_req_i) begin
                    state_d = SCAN;
                    idx_d   = '0; // Always start from line 0
                end
            end
            SCAN: begin
                if (dirty_q[idx_q]) begin
                    state_d = SETUP; // Needs a writeback
                end else if (last_line) begin
                    state_d = ACK;
                end else begin
                    idx_d = idx_q + 1'b1; // Clean, skip in one cycle
                end
            end
            SETUP: begin
                state_d = ACCESS;
            end
            ACCESS: begin
                // Slave may stretch the access phase
                if (pready_i) begin
                    clear_dirty = 1'b1;
                    if (last_line) begin
                        state_d = ACK;
                    end else begin
                        idx_d   = idx_q + 1'b1;
                        state_d = SCAN;
                    end
                end
            end
            ACK: begin
                flush_ack_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    // ----------------------------------------
    // APB drive
    // ----------------------------------------
    assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
    assign penable_o = (state_q == ACCESS);
    assign pwrite_o  = 1'b1;                    // Writebacks only
    assign paddr_o   = WB_BASE + {{(ADDR_W - LINE_IDX_W - 2){1'b0}}, idx_q, 2'b00};
    assign pwdata_o  = line_data_q[idx_q];

    // ----------------------------------------
    // Line data and dirty bits
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dirty_q <= '0;
            for (int i = 0; i < NR_LINES; i++) begin
                line_data_q[i] <= '0; // Cache comes up clean and zeroed
            end
        end else begin
            if (clear_dirty) begin
                dirty_q[idx_q] <= 1'b0;
            end
            // A store in the same cycle re-dirties its line
            if (store_valid_i) begin
                line_data_q[store_idx_i] <= store_data_i;
                dirty_q[store_idx_i]     <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    // Address and data hold while the slave stalls
    apb_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (psel_o && !pready_i) |=> ($stable(paddr_o) && $stable(pwdata_o))
    ) else $error("APB address or data changed during a stalled transfer");

    // Access phase only ever follows a setup phase
    apb_phase_order : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        penable_o |-> (psel_o && $past(psel_o))
    ) else $error("APB penable without preceding setup");

endmodule

// ==== rtl/flush_pkg.sv ====
// Shared geometry, writeback address map and walk encoding, imported by every flush RTL block
package flush_pkg;

    // ----------------------------------------
    // Data-cache geometry
    // ----------------------------------------
    localparam int unsigned NR_LINES   = 16;               // Lines in the data cache
    localparam int unsigned LINE_IDX_W = $clog2(NR_LINES); // Line index width
    localparam int unsigned DATA_W     = 32;               // One data word per line, APB data

    // ----------------------------------------
    // Writeback address map
    // ----------------------------------------
    localparam int unsigned ADDR_W = 32; // APB address width

    // Line i lands at WB_BASE + 4*i
    localparam logic [ADDR_W-1:0] WB_BASE = 32'h8000_0000;

    // ----------------------------------------
    // Flush walk states
    // ----------------------------------------
    // IDLE waits for a request
    // SCAN looks at the dirty bit of the current line
    // SETUP and ACCESS are the two APB phases of a writeback
    // ACK pulses the acknowledge for one cycle
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        SCAN   = 3'd1,
        SETUP  = 3'd2,
        ACCESS = 3'd3,
        ACK    = 3'd4
    } walk_state_e;

endpackage

// ==== rtl/flush_subsys.sv ====
// Top level of the flush subsystem, ties the flush controller to the dcache flush unit
module flush_subsys
    import flush_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Pipeline events
    input  logic                  mispredict_i,
    input  logic                  fence_i,
    input  logic                  fence_i_i,
    input  logic                  sfence_vma_i,
    input  logic                  flush_csr_i,
    input  logic                  ex_valid_i,
    input  logic                  eret_i,
    input  logic                  set_debug_pc_i,
    input  logic                  halt_csr_i,
    // Flush strobes
    output logic                  set_pc_commit_o,
    output logic                  flush_if_o,
    output logic                  flush_unissued_o,
    output logic                  flush_id_o,
    output logic                  flush_ex_o,
    output logic                  flush_icache_o,
    output logic                  flush_tlb_o,
    output logic                  halt_o,
    // Core store port
    input  logic                  store_valid_i,
    input  logic [LINE_IDX_W-1:0] store_idx_i,
    input  logic [DATA_W-1:0]     store_data_i,
    // APB writeback master
    output logic                  psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_W-1:0]     paddr_o,
    output logic [DATA_W-1:0]     pwdata_o,
    input  logic                  pready_i,
    input  logic                  pslverr_i
);

    // ----------------------------------------
    // Internal handshake
    // ----------------------------------------
    logic flush_dcache; // Controller request
    logic flush_ack;    // Unit done

    controller i_controller (
        .clk_i              ( clk_i            ),
        .rst_ni             ( rst_ni           ),
        .mispredict_i       ( mispredict_i     ),
        .fence_i            ( fence_i          ),
        .fence_i_i          ( fence_i_i        ),
        .sfence_vma_i       ( sfence_vma_i     ),
        .flush_csr_i        ( flush_csr_i      ),
        .ex_valid_i         ( ex_valid_i       ),
        .eret_i             ( eret_i           ),
        .set_debug_pc_i     ( set_debug_pc_i   ),
        .halt_csr_i         ( halt_csr_i       ),
        .set_pc_commit_o    ( set_pc_commit_o  ),
        .flush_if_o         ( flush_if_o       ),
        .flush_unissued_o   ( flush_unissued_o ),
        .flush_id_o         ( flush_id_o       ),
        .flush_ex_o         ( flush_ex_o       ),
        .flush_icache_o     ( flush_icache_o   ),
        .flush_tlb_o        ( flush_tlb_o      ),
        .flush_dcache_o     ( flush_dcache     ),
        .flush_dcache_ack_i ( flush_ack        ),
        .halt_o             ( halt_o           )
    );

    dcache_flush_unit i_dcache_flush_unit (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_req_i   ( flush_dcache  ),
        .flush_ack_o   ( flush_ack     ),
        .store_valid_i ( store_valid_i ),
        .store_idx_i   ( store_idx_i   ),
        .store_data_i  ( store_data_i  ),
        .psel_o        ( psel_o        ),
        .penable_o     ( penable_o     ),
        .pwrite_o      ( pwrite_o      ),
        .paddr_o       ( paddr_o       ),
        .pwdata_o      ( pwdata_o      ),
        .pready_i      ( pready_i      ),
        .pslverr_i     ( pslverr_i     )
    );

endmodule
